// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/1ps -j 0
TOP      = tb_centroid_report
FILELIST = centroid_report.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove $(BUILD) and $(LOG)"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "=== FAIL ===" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	elif ! grep -q "=== PASS ===" $(LOG); then \
		echo "Simulation ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)

// ==== centroid_report.f ====
centroid_report_pkg.sv
edge_detect.sv
hex_ascii_conv.sv
char_sender.sv
report_sequencer.sv
centroid_report.sv
tx_busy_model.sv
tb_centroid_report.sv

// ==== centroid_report.sv ====
// Top level with trigger edge detection, hex converters and report sequencer
module centroid_report #(
    parameter int SUM_S_W  = centroid_report_pkg::DEF_SUM_S_W,
    parameter int SUM_XY_W = centroid_report_pkg::DEF_SUM_XY_W
) (
    input  logic                       CLK,
    input  logic                       RST_N,
    input  logic [SUM_S_W-1:0]         sum_s,
    input  logic [SUM_XY_W-1:0]        sum_sx,
    input  logic [SUM_XY_W-1:0]        sum_sy,
    input  logic                       trig,
    input  logic                       tx_busy,
    output logic                       busy,
    output logic                       de,
    output centroid_report_pkg::char_t data
);

    logic                  start;
    logic [SUM_S_W*2-1:0]  text_s;
    logic [SUM_XY_W*2-1:0] text_sx;
    logic [SUM_XY_W*2-1:0] text_sy;

    // Trigger rise starts one report
    edge_detect u_trig_edge (
        .CLK   (CLK),
        .RST_N (RST_N),
        .level (trig),
        .rise  (start),
        .fall  ()
    );

    // ------------------------------------------------------------------
    // Free-running hex converters
    // ------------------------------------------------------------------

    hex_ascii_conv #(.WIDTH(SUM_S_W)) u_conv_s (
        .CLK   (CLK),
        .RST_N (RST_N),
        .value (sum_s),
        .text  (text_s)
    );

    hex_ascii_conv #(.WIDTH(SUM_XY_W)) u_conv_sx (
        .CLK   (CLK),
        .RST_N (RST_N),
        .value (sum_sx),
        .text  (text_sx)
    );

    hex_ascii_conv #(.WIDTH(SUM_XY_W)) u_conv_sy (
        .CLK   (CLK),
        .RST_N (RST_N),
        .value (sum_sy),
        .text  (text_sy)
    );

    report_sequencer #(
        .SUM_S_W  (SUM_S_W),
        .SUM_XY_W (SUM_XY_W)
    ) u_seq (
        .CLK     (CLK),
        .RST_N   (RST_N),
        .start   (start),
        .text_s  (text_s),
        .text_sx (text_sx),
        .text_sy (text_sy),
        .tx_busy (tx_busy),
        .busy    (busy),
        .de      (de),
        .data    (data)
    );

endmodule

// ==== centroid_report_pkg.sv ====
// Character type, ASCII constants, default sum widths and FSM state types
package centroid_report_pkg;

    // ------------------------------------------------------------------
    // Transmitter character bus
    // ------------------------------------------------------------------

    localparam int CHAR_W = 8;

    typedef logic [CHAR_W-1:0] char_t;

    // Value on data between strobes
    localparam char_t IDLE_CHAR = 8'hFF;

    // Line terminator
    localparam char_t LF_CHAR = 8'h0A;

    // Base characters for hex digits
    localparam char_t ZERO_CHAR    = 8'h30;
    localparam char_t UPPER_A_CHAR = 8'h41;

    // ------------------------------------------------------------------
    // Sum widths and field counting
    // ------------------------------------------------------------------

    // Bits per hex digit
    localparam int NIBBLE_W = 4;

    localparam int DEF_SUM_S_W  = 20;
    localparam int DEF_SUM_XY_W = 28;

    // Characters still to send in the current field
    typedef logic [3:0] digit_cnt_t;

    // ------------------------------------------------------------------
    // State machines
    // ------------------------------------------------------------------

    // Field order of one report line
    typedef enum logic [2:0] {
        SEQ_IDLE,
        SEQ_S,
        SEQ_SX,
        SEQ_SY,
        SEQ_LF,
        SEQ_DONE
    } seq_state_t;

    // Per-character handshake with the transmitter
    typedef enum logic [1:0] {
        SEND_IDLE,
        SEND_LOAD,
        SEND_STROBE,
        SEND_WAIT
    } send_state_t;

endpackage

// ==== char_sender.sv ====
// Field shifter that sends one character per transmitter handshake
module char_sender #(
    parameter int MAX_CHARS = 7
) (
    input  logic                                             CLK,
    input  logic                                             RST_N,
    input  logic                                             field_load,
    input  logic [MAX_CHARS*centroid_report_pkg::CHAR_W-1:0] field_text,
    input  centroid_report_pkg::digit_cnt_t                  field_len,
    input  logic                                             tx_busy,
    output logic                                             field_done,
    output logic                                             de,
    output centroid_report_pkg::char_t                       data
);

    import centroid_report_pkg::*;

    localparam int HOLD_W = MAX_CHARS * CHAR_W;

    send_state_t       state;
    logic [HOLD_W-1:0] hold;
    digit_cnt_t        remain;
    logic              busy_rise;
    logic              busy_fall;
    logic              take_char;

    edge_detect u_busy_edge (
        .CLK   (CLK),
        .RST_N (RST_N),
        .level (tx_busy),
        .rise  (busy_rise),
        .fall  (busy_fall)
    );

    // Next character leaves the hold register
    assign take_char = (state == SEND_LOAD) ||
                       (state == SEND_WAIT && busy_fall && remain != '0);

    // ------------------------------------------------------------------
    // Handshake FSM
    // ------------------------------------------------------------------

    always_ff @(posedge CLK or negedge RST_N) begin
        if (!RST_N) begin
            state      <= SEND_IDLE;
            remain     <= '0;
            field_done <= 1'b0;
            de         <= 1'b0;
            data       <= IDLE_CHAR;
        end else begin
            field_done <= 1'b0;
            case (state)
                SEND_IDLE: begin
                    if (field_load) begin
                        remain <= field_len;
                        state  <= SEND_LOAD;
                    end
                end
                SEND_LOAD: begin
                    state <= SEND_STROBE;
                end
                SEND_STROBE: begin
                    // Transmitter took the character
                    if (busy_rise) begin
                        de    <= 1'b0;
                        state <= SEND_WAIT;
                    end
                end
                SEND_WAIT: begin
                    if (busy_fall) begin
                        if (remain == '0) begin
                            field_done <= 1'b1;
                            data       <= IDLE_CHAR;
                            state      <= SEND_IDLE;
                        end else begin
                            state <= SEND_STROBE;
                        end
                    end
                end
                default: begin
                    de    <= 1'b0;
                    state <= SEND_IDLE;
                end
            endcase

            if (take_char) begin
                de     <= 1'b1;
                data   <= hold[HOLD_W-1 -: CHAR_W];
                remain <= remain - 1'b1;
            end
        end
    end

    // Hold register, first character at the top
    always_ff @(posedge CLK) begin
        if (state == SEND_IDLE && field_load) begin
            hold <= field_text;
        end else if (take_char) begin
            hold <= hold << CHAR_W;
        end
    end

    a_load_only_when_quiet: assert property (
        @(posedge CLK) disable iff (!RST_N) field_load |-> !de
    );

    a_data_held_through_strobe: assert property (
        @(posedge CLK) disable iff (!RST_N) $past(de) |-> $stable(data)
    );

endmodule

// ==== edge_detect.sv ====
// Registered rising and falling edge detector for a level input
module edge_detect (
    input  logic CLK,
    input  logic RST_N,
    input  logic level,
    output logic rise,
    output logic fall
);

    logic level_q1;
    logic level_q2;

    // Sample stage, then one cycle of history
    always_ff @(posedge CLK or negedge RST_N) begin
        if (!RST_N) begin
            level_q1 <= 1'b0;
            level_q2 <= 1'b0;
        end else begin
            level_q1 <= level;
            level_q2 <= level_q1;
        end
    end

    // Registered edge pulses, one cycle wide
    always_ff @(posedge CLK or negedge RST_N) begin
        if (!RST_N) begin
            rise <= 1'b0;
            fall <= 1'b0;
        end else begin
            rise <= level_q1 & ~level_q2;
            fall <= ~level_q1 & level_q2;
        end
    end

    // Rise pulse comes two samples after the input went high
    a_rise_follows_level: assert property (
        @(posedge CLK) disable iff (!RST_N) rise |-> $past(level, 2)
    );

endmodule

// ==== hex_ascii_conv.sv ====
// Registered conversion of a binary value into upper-case hex ASCII digits
module hex_ascii_conv #(
    parameter int WIDTH = 28
) (
    input  logic               CLK,
    input  logic               RST_N,
    input  logic [WIDTH-1:0]   value,
    output logic [WIDTH*2-1:0] text
);

    import centroid_report_pkg::*;

    localparam int DIGITS = WIDTH / NIBBLE_W;

    // ------------------------------------------------------------------
    // Nibble to character
    // ------------------------------------------------------------------

    function automatic char_t to_ascii(input logic [NIBBLE_W-1:0] nib);
        char_t c;
        if (nib < NIBBLE_W'(10)) begin
            c = ZERO_CHAR + char_t'(nib);
        end else begin
            c = UPPER_A_CHAR + char_t'(nib - NIBBLE_W'(10));
        end
        return c;
    endfunction

    // ------------------------------------------------------------------
    // Output register
    // ------------------------------------------------------------------

    // Digit i comes from nibble i, so the top character is the MSD
    always_ff @(posedge CLK or negedge RST_N) begin
        if (!RST_N) begin
            text <= {DIGITS{ZERO_CHAR}};
        end else begin
            for (int i = 0; i < DIGITS; i++) begin
                text[i*CHAR_W +: CHAR_W] <= to_ascii(value[i*NIBBLE_W +: NIBBLE_W]);
            end
        end
    end

endmodule

// ==== report_sequencer.sv ====
// Report field order FSM, snapshot of converted sums and report busy flag
module report_sequencer #(
    parameter int SUM_S_W  = centroid_report_pkg::DEF_SUM_S_W,
    parameter int SUM_XY_W = centroid_report_pkg::DEF_SUM_XY_W
) (
    input  logic                       CLK,
    input  logic                       RST_N,
    input  logic                       start,
    input  logic [SUM_S_W*2-1:0]       text_s,
    input  logic [SUM_XY_W*2-1:0]      text_sx,
    input  logic [SUM_XY_W*2-1:0]      text_sy,
    input  logic                       tx_busy,
    output logic                       busy,
    output logic                       de,
    output centroid_report_pkg::char_t data
);

    import centroid_report_pkg::*;

    localparam int MAX_CHARS = SUM_XY_W / NIBBLE_W;
    localparam int TEXT_W    = MAX_CHARS * CHAR_W;

    // Left alignment of the short S field and the LF character
    localparam int S_SHIFT  = TEXT_W - SUM_S_W * 2;
    localparam int LF_SHIFT = TEXT_W - CHAR_W;

    localparam digit_cnt_t S_LEN  = digit_cnt_t'(SUM_S_W / NIBBLE_W);
    localparam digit_cnt_t XY_LEN = digit_cnt_t'(MAX_CHARS);
    localparam digit_cnt_t LF_LEN = digit_cnt_t'(1);

    seq_state_t        state;
    logic              launch;
    logic [TEXT_W-1:0] snap_sx;
    logic [TEXT_W-1:0] snap_sy;
    logic [TEXT_W-1:0] field_text;
    digit_cnt_t        field_len;
    logic              field_load;
    logic              field_done;

    // A new line only starts while no report is in flight
    assign launch = start && (state == SEQ_IDLE || state == SEQ_DONE);

    // ------------------------------------------------------------------
    // Field order
    // ------------------------------------------------------------------

    always_ff @(posedge CLK or negedge RST_N) begin
        if (!RST_N) begin
            state      <= SEQ_IDLE;
            busy       <= 1'b0;
            field_load <= 1'b0;
        end else begin
            field_load <= 1'b0;
            case (state)
                SEQ_IDLE, SEQ_DONE: begin
                    if (launch) begin
                        busy       <= 1'b1;
                        field_load <= 1'b1;
                        state      <= SEQ_S;
                    end else begin
                        state <= SEQ_IDLE;
                    end
                end
                SEQ_S: begin
                    if (field_done) begin
                        field_load <= 1'b1;
                        state      <= SEQ_SX;
                    end
                end
                SEQ_SX: begin
                    if (field_done) begin
                        field_load <= 1'b1;
                        state      <= SEQ_SY;
                    end
                end
                SEQ_SY: begin
                    if (field_done) begin
                        field_load <= 1'b1;
                        state      <= SEQ_LF;
                    end
                end
                SEQ_LF: begin
                    if (field_done) begin
                        busy  <= 1'b0;
                        state <= SEQ_DONE;
                    end
                end
                default: begin
                    busy  <= 1'b0;
                    state <= SEQ_IDLE;
                end
            endcase
        end
    end

    // ------------------------------------------------------------------
    // Snapshot and field select
    // ------------------------------------------------------------------

    always_ff @(posedge CLK) begin
        if (launch) begin
            snap_sx    <= text_sx;
            snap_sy    <= text_sy;
            field_text <= TEXT_W'(text_s) << S_SHIFT;
            field_len  <= S_LEN;
        end else if (field_done) begin
            case (state)
                SEQ_S: begin
                    field_text <= snap_sx;
                    field_len  <= XY_LEN;
                end
                SEQ_SX: begin
                    field_text <= snap_sy;
                    field_len  <= XY_LEN;
                end
                SEQ_SY: begin
                    field_text <= TEXT_W'(LF_CHAR) << LF_SHIFT;
                    field_len  <= LF_LEN;
                end
                default: begin
                end
            endcase
        end
    end

    char_sender #(
        .MAX_CHARS (MAX_CHARS)
    ) u_sender (
        .CLK        (CLK),
        .RST_N      (RST_N),
        .field_load (field_load),
        .field_text (field_text),
        .field_len  (field_len),
        .tx_busy    (tx_busy),
        .field_done (field_done),
        .de         (de),
        .data       (data)
    );

    a_strobe_inside_report: assert property (
        @(posedge CLK) disable iff (!RST_N) de |-> busy
    );

endmodule

// ==== tb_centroid_report.sv ====
// Testbench for centroid_report with directed report tests and a transmitter model
module tb_centroid_report;

    timeunit 1ns;
    timeprecision 1ps;

    import centroid_report_pkg::*;

    localparam int SUM_S_W    = DEF_SUM_S_W;
    localparam int SUM_XY_W   = DEF_SUM_XY_W;
    localparam int LINE_CHARS = 20;
    // Each report line is one test, the idle check one more
    localparam int NUM_TESTS   = 14;
    localparam int MAX_BUSY    = 16;
    localparam int CYCLE_LIMIT = NUM_TESTS * LINE_CHARS * (MAX_BUSY + 8);

    logic                CLK;
    logic                RST_N;
    logic [SUM_S_W-1:0]  sum_s;
    logic [SUM_XY_W-1:0] sum_sx;
    logic [SUM_XY_W-1:0] sum_sy;
    logic                trig;
    logic                tx_busy;
    logic                busy;
    logic                de;
    char_t               data;
    logic [3:0]          resp_delay;
    logic [7:0]          busy_len;

    char_t       line_q[$];
    logic        tx_busy_q = 1'b0;
    logic        de_q = 1'b0;
    char_t       data_q = IDLE_CHAR;
    int          cycles = 0;
    int          checks = 0;
    int          errors = 0;
    logic [31:0] rng = 32'd33;

    centroid_report dut (
        .CLK     (CLK),
        .RST_N   (RST_N),
        .sum_s   (sum_s),
        .sum_sx  (sum_sx),
        .sum_sy  (sum_sy),
        .trig    (trig),
        .tx_busy (tx_busy),
        .busy    (busy),
        .de      (de),
        .data    (data)
    );

    tx_busy_model u_tx_model (
        .CLK        (CLK),
        .RST_N      (RST_N),
        .de         (de),
        .resp_delay (resp_delay),
        .busy_len   (busy_len),
        .tx_busy    (tx_busy)
    );

    always #2 CLK = ~CLK;

    always @(posedge CLK) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("=== FAIL ===");
            $finish;
        end
    end

    // ------------------------------------------------------------------
    // Compare helpers and expected text
    // ------------------------------------------------------------------

    task automatic check_char(input char_t got, input char_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL at time %0t: %s is 0x%02h, expected 0x%02h", $time, what, got, exp);
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL at time %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    function automatic logic [31:0] next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    // Upper-case hex of all three sums, then LF
    function automatic string expected_line(input logic [SUM_S_W-1:0] s,
                                            input logic [SUM_XY_W-1:0] sx,
                                            input logic [SUM_XY_W-1:0] sy);
        string t;
        t = $sformatf("%h%h%h", s, sx, sy);
        t = t.toupper();
        return {t, "\n"};
    endfunction

    // Capture on the first tx_busy cycle of each strobe
    always @(posedge CLK) begin
        if (de && tx_busy && !tx_busy_q) begin
            line_q.push_back(data);
        end
        if (de_q) begin
            check_char(data, data_q, "data while de high");
        end
        if (de && !de_q) begin
            check_bit(tx_busy, 1'b0, "tx_busy at de rise");
        end
        tx_busy_q <= tx_busy;
        de_q      <= de;
        data_q    <= data;
    end

    task automatic compare_line(input string exp);
        int n;
        n = (line_q.size() < exp.len()) ? line_q.size() : exp.len();
        if (line_q.size() != exp.len()) begin
            errors++;
            $display("FAIL at time %0t: line has %0d characters, expected %0d",
                     $time, line_q.size(), exp.len());
        end
        for (int i = 0; i < n; i++) begin
            check_char(line_q[i], char_t'(exp[i]), $sformatf("character %0d", i));
        end
    endtask

    task automatic pulse_trig();
        trig = 1'b1;
        repeat (2) @(negedge CLK);
        trig = 1'b0;
    endtask

    task automatic start_report(input logic [SUM_S_W-1:0] s,
                                input logic [SUM_XY_W-1:0] sx,
                                input logic [SUM_XY_W-1:0] sy);
        int wait_cnt;
        line_q.delete();
        sum_s  = s;
        sum_sx = sx;
        sum_sy = sy;
        repeat (3) @(negedge CLK);
        pulse_trig();
        wait_cnt = 0;
        while (!busy && wait_cnt < 8) begin
            @(negedge CLK);
            wait_cnt++;
        end
        if (!busy) begin
            errors++;
            $display("Error at time %0t: busy did not rise after the trigger", $time);
        end
    endtask

    task automatic finish_report();
        while (busy) begin
            @(negedge CLK);
        end
    endtask

    // ------------------------------------------------------------------
    // Directed tests
    // ------------------------------------------------------------------

    task automatic reset_values_hold();
        repeat (LINE_CHARS) begin
            check_bit(busy, 1'b0, "busy after reset");
            check_bit(de, 1'b0, "de after reset");
            check_char(data, IDLE_CHAR, "data after reset");
            @(negedge CLK);
        end
    endtask

    task automatic known_report_line();
        resp_delay = 4'd0;
        busy_len   = 8'd1;
        start_report(20'h1A2B3, 28'h0FEDCBA, 28'h1234567);
        finish_report();
        compare_line("1A2B30FEDCBA1234567\n");
        check_bit(de, 1'b0, "de at report end");
        check_char(data, IDLE_CHAR, "data at report end");
    endtask

    task automatic back_pressure_line();
        logic [31:0] r;
        resp_delay = 4'd3;
        busy_len   = 8'd12;
        start_report(20'h1A2B3, 28'h0FEDCBA, 28'h1234567);
        // Irregular transmitter timing, new on every cycle of the line
        while (busy) begin
            r          = next_rand();
            resp_delay = {2'b00, r[1:0]};
            busy_len   = 8'd4 + {4'd0, r[11:8]} % 8'd9;
            @(negedge CLK);
        end
        compare_line("1A2B30FEDCBA1234567\n");
    endtask

    task automatic retrigger_ignored();
        resp_delay = 4'd1;
        busy_len   = 8'd2;
        start_report(20'hC0FFE, 28'hABCDEF1, 28'h2468ACE);
        while (line_q.size() < 5) begin
            @(negedge CLK);
        end
        sum_s  = 20'h11111;
        sum_sx = 28'h2222222;
        sum_sy = 28'h3333333;
        repeat (3) @(negedge CLK);
        pulse_trig();
        finish_report();
        repeat (12) begin
            @(negedge CLK);
            check_bit(busy, 1'b0, "busy after ignored retrigger");
        end
        compare_line(expected_line(20'hC0FFE, 28'hABCDEF1, 28'h2468ACE));
    endtask

    task automatic random_report_lines();
        logic [SUM_S_W-1:0]  s;
        logic [SUM_XY_W-1:0] sx;
        logic [SUM_XY_W-1:0] sy;
        logic [31:0]         r;
        for (int n = 0; n < 10; n++) begin
            r          = next_rand();
            s          = r[SUM_S_W-1:0];
            r          = next_rand();
            sx         = r[SUM_XY_W-1:0];
            r          = next_rand();
            sy         = r[SUM_XY_W-1:0];
            r          = next_rand();
            resp_delay = {2'b00, r[1:0]};
            busy_len   = 8'd1 + {6'd0, r[9:8]};
            start_report(s, sx, sy);
            finish_report();
            compare_line(expected_line(s, sx, sy));
        end
    endtask

    initial begin
        CLK        = 1'b0;
        RST_N      = 1'b0;
        trig       = 1'b0;
        sum_s      = '0;
        sum_sx     = '0;
        sum_sy     = '0;
        resp_delay = 4'd0;
        busy_len   = 8'd1;
        repeat (2) @(negedge CLK);
        RST_N = 1'b1;

        reset_values_hold();
        known_report_line();
        back_pressure_line();
        retrigger_ignored();
        random_report_lines();

        $display("Checks: %0d  errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// ==== tx_busy_model.sv ====
// UART transmitter model that answers each de strobe with a busy pulse
module tx_busy_model (
    input  logic       CLK,
    input  logic       RST_N,
    input  logic       de,
    input  logic [3:0] resp_delay,
    input  logic [7:0] busy_len,
    output logic       tx_busy
);

    timeunit 1ns;
    timeprecision 1ps;

    logic [3:0] delay_now;
    logic [7:0] len_now;

    // busy_len must be at least 1 for the DUT to see a rising edge
    initial begin
        tx_busy = 1'b0;
        forever begin
            @(posedge CLK);
            if (RST_N && de) begin
                // Timing for this character
                delay_now = resp_delay;
                len_now   = busy_len;
                @(negedge CLK);
                repeat (delay_now) begin
                    @(negedge CLK);
                end
                tx_busy = 1'b1;
                repeat (len_now) begin
                    @(negedge CLK);
                end
                tx_busy = 1'b0;
                // Re-arm once the strobe is withdrawn
                while (de) begin
                    @(negedge CLK);
                end
            end
        end
    end

endmodule
